//--- design/board_pkg.sv
package board_pkg;

    localparam int clk_mhz = 100;

    // board buttons, switches and leds
    localparam int w_key = 4;
    localparam int w_sw  = 4;
    localparam int w_led = 4;

    localparam int w_tm_key   = 8;
    localparam int w_tm_led   = 8;
    localparam int w_tm_digit = 8;

    // duplicate mode, the lab sees whichever key and led set is wider
    localparam int w_lab_key = w_tm_key > w_key ? w_tm_key : w_key;
    localparam int w_lab_led = w_tm_led > w_led ? w_tm_led : w_led;

    typedef logic [w_lab_key  - 1:0] key_t;
    typedef logic [w_lab_led  - 1:0] led_t;
    typedef logic [w_tm_digit - 1:0] digit_t;
    typedef logic [7:0]              seg_t;      // abcdefgh, a is the msb
    typedef logic [11:0]             mic_raw_t;
    typedef logic signed [23:0]      mic_t;

    localparam int tick_div_default = clk_mhz * 1_000_000;  // one tick per second
    localparam int spi_sck_half     = 4;
    localparam int sio_clk_half     = 2;

    localparam logic [7:0] tm_cmd_write_auto = 8'h40;
    localparam logic [7:0] tm_cmd_addr0      = 8'hc0;
    localparam logic [7:0] tm_cmd_read_keys  = 8'h42;
    localparam logic [7:0] tm_cmd_display_on = 8'h8f;  // display on at full brightness

    typedef enum logic [2:0]
    {
        st_idle,
        st_load,
        st_clk_low,
        st_clk_high,
        st_stb_gap
    } tm_state_t;

    function automatic seg_t hex_to_seg (input logic [3:0] nibble);
        seg_t seg;
        case (nibble)
            4'h0: seg = 8'hfc;  4'h1: seg = 8'h60;  4'h2: seg = 8'hda;  4'h3: seg = 8'hf2;
            4'h4: seg = 8'h66;  4'h5: seg = 8'hb6;  4'h6: seg = 8'hbe;  4'h7: seg = 8'he0;
            4'h8: seg = 8'hfe;  4'h9: seg = 8'hf6;  4'ha: seg = 8'hee;  4'hb: seg = 8'h3e;
            4'hc: seg = 8'h9c;  4'hd: seg = 8'h7a;  4'he: seg = 8'h9e;  default: seg = 8'h8e;
        endcase
        return seg;
    endfunction

endpackage

//--- design/slow_tick_gen.sv
`timescale 1ns/10ps

module slow_tick_gen
#(
    parameter int tick_div = board_pkg::tick_div_default
)
(
    input        clk,
    input        rst_n,
    output logic slow_tick
);

    logic [31:0] cnt;

    // counts down to zero, then reloads and fires the tick
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cnt       <= 32'(tick_div - 1);
            slow_tick <= 1'b0;
        end
        else if (cnt == 32'd0)
        begin
            cnt       <= 32'(tick_div - 1);
            slow_tick <= 1'b1;
        end
        else
        begin
            cnt       <= cnt - 32'd1;
            slow_tick <= 1'b0;  // high for a single cycle only
        end
    end

endmodule

//--- design/mic3_spi_receiver.sv
`timescale 1ns/10ps

module mic3_spi_receiver
(
    input                       clk,
    input                       rst_n,
    output logic                cs,
    output logic                sck,
    input                       sdo,
    output board_pkg::mic_raw_t value
);

    logic [7:0] half_cnt;    // clock cycles inside one sck half period
    logic [5:0] half_idx;    // halves 0 and 1 are the cs gap, 2 to 33 the 16 sck periods
    logic [5:0] next_half;
    logic       half_done;
    logic       frame_end;

    board_pkg::mic_raw_t shift;

    assign half_done = half_cnt == 8'(board_pkg::spi_sck_half - 1);
    assign next_half = (half_idx == 6'd33) ? 6'd0 : half_idx + 6'd1;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            half_cnt  <= 8'd0;
            half_idx  <= 6'd0;
            cs        <= 1'b1;
            sck       <= 1'b1;
            frame_end <= 1'b0;
        end
        else
        begin
            // pulses together with the rise of cs
            frame_end <= half_done && half_idx == 6'd33;

            if (half_done)
            begin
                half_cnt <= 8'd0;
                half_idx <= next_half;
                cs       <= next_half < 6'd2;
                sck      <= next_half < 6'd2 || next_half[0];  // even halves are low
            end
            else
            begin
                half_cnt <= half_cnt + 8'd1;
            end
        end
    end

    // sdo moved after the falling edge, so take it as sck rises
    always_ff @(posedge clk)
    begin
        if (half_done && next_half >= 6'd3 && next_half[0])
        begin
            shift <= {shift[10:0], sdo};  // the four leading zeros fall off the top
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            value <= '0;
        else if (frame_end)
            value <= shift;
    end

endmodule

//--- design/tm1638_controller.sv
`timescale 1ns/10ps

module tm1638_controller
(
    input                     clk,
    input                     rst_n,
    input  board_pkg::seg_t   hgfedcba,
    input  board_pkg::digit_t digit,
    input  board_pkg::led_t   ledr,
    output board_pkg::key_t   keys,
    output logic              sio_clk,
    output logic              sio_stb,
    output logic              sio_dout,
    output logic              sio_doe,
    input                     sio_din
);

    board_pkg::tm_state_t state;

    board_pkg::seg_t seg_store [board_pkg::w_tm_digit];
    board_pkg::seg_t seg_snap  [board_pkg::w_tm_digit];
    board_pkg::led_t led_snap;
    board_pkg::key_t key_acc;

    logic [1:0] cmd_idx;    // four commands per frame
    logic [4:0] byte_idx;   // byte 0 is the command itself
    logic [4:0] last_byte;
    logic [4:0] data_idx;
    logic [2:0] bit_idx;
    logic [7:0] half_cnt;
    logic [7:0] shift;
    logic [7:0] tx_byte;
    logic       half_done;
    logic       rd_phase;
    logic [1:0] rd_k;

    assign half_done = half_cnt == 8'(board_pkg::sio_clk_half - 1);
    assign data_idx  = byte_idx - 5'd1;
    assign rd_phase  = cmd_idx == 2'd3 && byte_idx != 5'd0;
    assign rd_k      = data_idx[1:0];  // read byte number

    // the lab scans one digit per cycle, keep each one while it is selected
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < board_pkg::w_tm_digit; i++)
            begin
                seg_store[i] <= '0;
            end
        end
        else
        begin
            for (int i = 0; i < board_pkg::w_tm_digit; i++)
            begin
                if (digit[i])
                    seg_store[i] <= hgfedcba;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == board_pkg::st_idle)
        begin
            seg_snap <= seg_store;  // one consistent picture per frame
            led_snap <= ledr;
        end
    end

    always_comb
    begin
        case (cmd_idx)
            2'd0:
            begin
                last_byte = 5'd0;
                tx_byte   = board_pkg::tm_cmd_write_auto;
            end
            2'd1:
            begin
                last_byte = 5'd16;
                if (byte_idx == 5'd0)
                    tx_byte = board_pkg::tm_cmd_addr0;
                else if (!data_idx[0])
                    tx_byte = seg_snap[data_idx[3:1]];
                else
                    tx_byte = {7'd0, led_snap[data_idx[3:1]]};  // odd addresses hold the leds
            end
            2'd2:
            begin
                last_byte = 5'd0;
                tx_byte   = board_pkg::tm_cmd_display_on;
            end
            default:
            begin
                last_byte = 5'd4;
                tx_byte   = (byte_idx == 5'd0) ? board_pkg::tm_cmd_read_keys : 8'h00;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (state == board_pkg::st_load)
            shift <= tx_byte;
        else if (state == board_pkg::st_clk_high && half_done)
            shift <= shift >> 1;  // lsb goes out first

        // bits 0 and 4 of each read byte carry the keys
        if (state == board_pkg::st_clk_low && half_done && rd_phase)
        begin
            if (bit_idx == 3'd0)
                key_acc[{1'b0, rd_k}] <= sio_din;
            if (bit_idx == 3'd4)
                key_acc[{1'b1, rd_k}] <= sio_din;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state    <= board_pkg::st_idle;
            cmd_idx  <= 2'd0;
            byte_idx <= 5'd0;
            bit_idx  <= 3'd0;
            half_cnt <= 8'd0;
            sio_clk  <= 1'b1;
            sio_stb  <= 1'b1;
            sio_dout <= 1'b0;
            sio_doe  <= 1'b0;
            keys     <= '0;
        end
        else
        begin
            case (state)
                board_pkg::st_idle:
                begin
                    state <= board_pkg::st_load;
                end
                board_pkg::st_load:
                begin
                    sio_stb  <= 1'b0;
                    sio_clk  <= 1'b0;
                    sio_doe  <= !rd_phase;  // let the module drive the line on reads
                    bit_idx  <= 3'd0;
                    half_cnt <= 8'd0;
                    state    <= board_pkg::st_clk_low;
                end
                board_pkg::st_clk_low:
                begin
                    if (half_cnt == 8'd0)
                        sio_dout <= shift[0];
                    if (half_done)
                    begin
                        sio_clk  <= 1'b1;
                        half_cnt <= 8'd0;
                        state    <= board_pkg::st_clk_high;
                    end
                    else
                    begin
                        half_cnt <= half_cnt + 8'd1;
                    end
                end
                board_pkg::st_clk_high:
                begin
                    if (!half_done)
                    begin
                        half_cnt <= half_cnt + 8'd1;
                    end
                    else if (bit_idx != 3'd7)
                    begin
                        half_cnt <= 8'd0;
                        bit_idx  <= bit_idx + 3'd1;
                        sio_clk  <= 1'b0;
                        state    <= board_pkg::st_clk_low;
                    end
                    else if (byte_idx != last_byte)
                    begin
                        byte_idx <= byte_idx + 5'd1;
                        state    <= board_pkg::st_load;
                    end
                    else
                    begin
                        half_cnt <= 8'd0;
                        sio_stb  <= 1'b1;
                        sio_doe  <= 1'b0;
                        state    <= board_pkg::st_stb_gap;
                    end
                end
                default:
                begin
                    // first cycle with stb high after the reads closes the frame
                    if (half_cnt == 8'd0 && cmd_idx == 2'd3)
                        keys <= key_acc;
                    if (half_cnt == 8'(2 * board_pkg::sio_clk_half - 1))
                    begin
                        half_cnt <= 8'd0;
                        byte_idx <= 5'd0;
                        cmd_idx  <= cmd_idx + 2'd1;
                        state    <= (cmd_idx == 2'd3) ? board_pkg::st_idle : board_pkg::st_load;
                    end
                    else
                    begin
                        half_cnt <= half_cnt + 8'd1;
                    end
                end
            endcase
        end
    end

endmodule

//--- design/lab_top.sv
`timescale 1ns/10ps

module lab_top
(
    input                          clk,
    input                          rst_n,
    input                          slow_tick,
    input  board_pkg::key_t        key,
    input  [board_pkg::w_sw - 1:0] sw,
    input  board_pkg::mic_t        mic,
    output board_pkg::led_t        led,
    output board_pkg::seg_t        abcdefgh,
    output board_pkg::digit_t      digit
);

    logic [15:0] count;
    logic [2:0]  scan;    // digit being shown this cycle
    logic [3:0]  nibble;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            count <= 16'd0;
            scan  <= 3'd0;
        end
        else
        begin
            scan <= scan + 3'd1;
            if (slow_tick)
                count <= count + 16'd1;
        end
    end

    always_comb
    begin
        case (scan)
            3'd0:    nibble = count[3:0];
            3'd1:    nibble = count[7:4];
            3'd2:    nibble = count[11:8];
            3'd3:    nibble = count[15:12];
            3'd4:    nibble = mic[3:0];
            3'd5:    nibble = mic[7:4];
            3'd6:    nibble = mic[11:8];
            default: nibble = 4'd0;
        endcase
    end

    // the last digit stays dark
    assign abcdefgh = (scan == 3'd7) ? '0 : board_pkg::hex_to_seg(nibble);

    assign digit = board_pkg::digit_t'(1) << scan;  // one hot select

    assign led = key ^ board_pkg::led_t'(sw);

endmodule

//--- design/board_top.sv
`timescale 1ns/10ps

module board_top
#(
    parameter int tick_div = board_pkg::tick_div_default
)
(
    input                           clk,
    input                           rst_n,
    input  [board_pkg::w_key - 1:0] btn,
    input  [board_pkg::w_sw  - 1:0] sw,
    output [board_pkg::w_led - 1:0] led,
    output                          mic_cs,
    output                          mic_sck,
    input                           mic_sdo,
    output                          sio_clk,
    output                          sio_stb,
    output                          sio_dout,
    output                          sio_doe,
    input                           sio_din
);

    logic                slow_tick;
    board_pkg::mic_raw_t mic_raw;
    board_pkg::mic_raw_t mic_centered;
    board_pkg::mic_t     mic;
    board_pkg::key_t     tm_key;
    board_pkg::key_t     lab_key;
    board_pkg::led_t     lab_led;
    board_pkg::led_t     tm_led;
    board_pkg::seg_t     abcdefgh;
    board_pkg::seg_t     hgfedcba;
    board_pkg::digit_t   lab_digit;

    // buttons and tm1638 keys act as one key set
    always_comb
    begin
        lab_key = '0;
        lab_key[board_pkg::w_key    - 1:0] |= btn;
        lab_key[board_pkg::w_tm_key - 1:0] |= tm_key;
    end

    assign led    = lab_led[board_pkg::w_led    - 1:0];
    assign tm_led = lab_led[board_pkg::w_tm_led - 1:0];

    // converter idles at mid scale
    assign mic_centered = mic_raw - 12'h800;
    assign mic          = {{12{mic_centered[11]}}, mic_centered};

    // the tm1638 wants segment a in bit 0
    generate
        for (genvar i = 0; i < $bits(board_pkg::seg_t); i++)
        begin : g_seg_rev
            assign hgfedcba[i] = abcdefgh[$bits(board_pkg::seg_t) - 1 - i];
        end
    endgenerate

    slow_tick_gen #(.tick_div (tick_div)) i_slow_tick_gen
    (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .slow_tick ( slow_tick )
    );

    mic3_spi_receiver i_mic
    (
        .clk   ( clk     ),
        .rst_n ( rst_n   ),
        .cs    ( mic_cs  ),
        .sck   ( mic_sck ),
        .sdo   ( mic_sdo ),
        .value ( mic_raw )
    );

    lab_top i_lab_top
    (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .slow_tick ( slow_tick ),
        .key       ( lab_key   ),
        .sw        ( sw        ),
        .mic       ( mic       ),
        .led       ( lab_led   ),
        .abcdefgh  ( abcdefgh  ),
        .digit     ( lab_digit )
    );

    tm1638_controller i_ledkey
    (
        .clk      ( clk       ),
        .rst_n    ( rst_n     ),
        .hgfedcba ( hgfedcba  ),
        .digit    ( lab_digit ),
        .ledr     ( tm_led    ),
        .keys     ( tm_key    ),
        .sio_clk  ( sio_clk   ),
        .sio_stb  ( sio_stb   ),
        .sio_dout ( sio_dout  ),
        .sio_doe  ( sio_doe   ),
        .sio_din  ( sio_din   )
    );

endmodule

//--- verification/tb_clock.sv
`timescale 1ns/10ps

module tb_clock
#(
    parameter int half_period = 2  // 4 ns period
)
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

endmodule

//--- verification/board_top_properties.sv
`timescale 1ns/10ps

module board_top_properties
(
    input clk,
    input rst_n,
    input sio_stb,
    input sio_doe,
    input mic_cs,
    input mic_sck
);

    // the data line is only driven inside a command window
    property doe_inside_stb;
        @(posedge clk) disable iff (!rst_n)
        sio_stb |-> !sio_doe;
    endproperty

    // sck idles high between microphone frames
    property sck_idle_high;
        @(posedge clk) disable iff (!rst_n)
        mic_cs |-> mic_sck;
    endproperty

    property idle_after_reset;
        @(posedge clk)
        $rose(rst_n) |-> sio_stb && mic_cs;
    endproperty

    a_doe_inside_stb:   assert property (doe_inside_stb)   else $error("sio_doe high outside a strobe");
    a_sck_idle_high:    assert property (sck_idle_high)    else $error("mic_sck low while mic_cs high");
    a_idle_after_reset: assert property (idle_after_reset) else $error("buses not idle after reset");

endmodule

//--- verification/board_top_tb.sv
`timescale 1ns/10ps

module board_top_tb;

    localparam int tick_div    = 200;
    localparam int frame_limit = 2000;  // cycles allowed for one display frame

    logic                           clk;
    logic                           rst_n;
    logic [board_pkg::w_key - 1:0]  btn;
    logic [board_pkg::w_sw  - 1:0]  sw;
    logic [board_pkg::w_led - 1:0]  led;
    logic                           mic_cs;
    logic                           mic_sck;
    logic                           mic_sdo = 1'b0;
    logic                           sio_clk;
    logic                           sio_stb;
    logic                           sio_dout;
    logic                           sio_doe;
    logic                           sio_din = 1'b0;

    logic [31:0]         seed;
    logic [11:0]         mic_sample;
    logic [7:0]          key_bytes [4];
    logic [7:0]          shown_seg [8];
    logic [7:0]          shown_led [8];
    logic [7:0]          win_bytes [$];
    logic [7:0]          frame_bytes [$];
    int                  win_sizes [$];
    logic [7:0]          sh;
    logic                prev_sck;
    logic                prev_sclk;
    logic                prev_stb;
    int                  mic_fall;
    int                  bitc;
    int                  frame_cnt;
    int                  err_cnt;
    int                  check_cnt;
    int                  cur_count;
    int                  prev_count;
    int                  nib;
    int                  acc;
    logic                valid;
    logic                timed_out;
    longint              cyc;
    longint              start_cycle;
    longint              cur_start;
    longint              prev_start;

    tb_clock u_clock (.clk (clk));

    board_top #(.tick_div (tick_div)) u_board_top (.*);

    bind board_top board_top_properties u_board_top_properties (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [7:0] reverse_bits(input logic [7:0] b);
        logic [7:0] r;
        for (int i = 0; i < 8; i++)
            r[i] = b[7 - i];
        return r;
    endfunction

    // tm1638 side sees segment a in bit 0
    function automatic int nibble_of(input logic [7:0] pattern);
        for (int n = 0; n < 16; n++)
        begin
            if (reverse_bits(board_pkg::hex_to_seg(4'(n))) == pattern)
                return n;
        end
        return -1;
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        check_cnt++;
        assert (expected == actual)
        else
        begin
            err_cnt++;
            $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic wait_frames(input int n);
        int target;
        int waited;
        target = frame_cnt + n;
        waited = 0;
        while (frame_cnt < target && !timed_out)
        begin
            @(posedge clk);
            waited++;
            if (waited > n * frame_limit)
            begin
                timed_out = 1'b1;
                err_cnt++;
                $display("Timeout: the TM1638 bus stopped completing frames");
            end
        end
    endtask

    always @(posedge clk)
        cyc <= cyc + 1;

    // mic3 converter, moves sdo after each falling sck
    always @(negedge clk)
    begin
        if (!rst_n)
        begin
            prev_sck = 1'b1;
            mic_fall = 0;
            mic_sdo  <= 1'b0;
        end
        else
        begin
            if (mic_cs)
                mic_fall = 0;
            else if (prev_sck && !mic_sck)
            begin
                mic_sdo <= (mic_fall < 4) ? 1'b0 : mic_sample[15 - mic_fall];
                mic_fall++;
            end
            prev_sck = mic_sck;
        end
    end

    // tm1638 module, collects windows and answers the key read
    always @(negedge clk)
    begin
        if (!rst_n)
        begin
            prev_sclk = 1'b1;
            prev_stb  = 1'b1;
            bitc      = 0;
            sio_din   <= 1'b0;
            win_bytes.delete();
            frame_bytes.delete();
            win_sizes.delete();
            start_cycle = cyc;
        end
        else
        begin
            if (prev_stb && !sio_stb)
            begin
                bitc = 0;
                win_bytes.delete();
            end
            if (!sio_stb && sio_clk && !prev_sclk)
            begin
                if (sio_doe)
                    sh = {sio_dout, sh[7:1]};  // lsb arrives first
                bitc++;
                if (sio_doe && bitc % 8 == 0)
                    win_bytes.push_back(sh);
            end
            if (!prev_stb && sio_stb)
            begin
                win_sizes.push_back(win_bytes.size());
                foreach (win_bytes[i])
                    frame_bytes.push_back(win_bytes[i]);
                if (win_bytes.size() > 0 && win_bytes[0] == board_pkg::tm_cmd_read_keys)
                begin
                    check_value("command windows", 4, win_sizes.size());
                    if (win_sizes.size() == 4)
                    begin
                        check_value("write window size", 1, win_sizes[0]);
                        check_value("address window size", 17, win_sizes[1]);
                        check_value("display window size", 1, win_sizes[2]);
                    end
                    check_value("frame byte count", 20, frame_bytes.size());
                    if (frame_bytes.size() == 20)
                    begin
                        check_value("write command", 8'h40, frame_bytes[0]);
                        check_value("address command", 8'hc0, frame_bytes[1]);
                        check_value("display command", 8'h8f, frame_bytes[18]);
                        check_value("read command", 8'h42, frame_bytes[19]);
                        for (int d = 0; d < 8; d++)
                        begin
                            shown_seg[d] = frame_bytes[2 + 2 * d];
                            shown_led[d] = frame_bytes[3 + 2 * d];
                        end
                    end
                    acc   = 0;
                    valid = 1'b1;
                    for (int d = 3; d >= 0; d--)
                    begin
                        nib = nibble_of(shown_seg[d]);
                        valid &= nib >= 0;
                        acc = acc * 16 + nib;
                    end
                    prev_count  = cur_count;
                    cur_count   = valid ? acc : -1;
                    prev_start  = cur_start;
                    cur_start   = start_cycle;  // the frame snapshot follows the previous end
                    start_cycle = cyc;
                    frame_bytes.delete();
                    win_sizes.delete();
                    frame_cnt++;
                end
            end
            if (!sio_stb && !sio_doe && bitc >= 8 && bitc < 40 && win_bytes.size() == 1
                && win_bytes[0] == board_pkg::tm_cmd_read_keys)
                sio_din <= key_bytes[(bitc - 8) / 8][(bitc - 8) % 8];
            else
                sio_din <= 1'b0;
            prev_sclk = sio_clk;
            prev_stb  = sio_stb;
        end
    end

    task automatic check_frame(input logic [7:0] exp_led);
        logic [11:0] centered;
        int          exp_inc;
        int          act_inc;
        centered = mic_sample - 12'h800;
        for (int d = 0; d < 8; d++)
            check_value($sformatf("led byte %0d", d), exp_led[d], shown_led[d]);
        for (int i = 0; i < 3; i++)
            check_value($sformatf("mic digit %0d", 4 + i),
                        reverse_bits(board_pkg::hex_to_seg(centered[4 * i +: 4])), shown_seg[4 + i]);
        check_value("blank digit", 0, shown_seg[7]);
        check_cnt++;
        if (cur_count < 0 || prev_count < 0)
        begin
            err_cnt++;
            $display("Count digits 0 to 3 do not show hex patterns");
        end
        else
        begin
            exp_inc = int'((cur_start - prev_start) / tick_div);
            act_inc = cur_count - prev_count;
            assert (act_inc >= exp_inc - 1 && act_inc <= exp_inc + 1)
            else
            begin
                err_cnt++;
                $display("** Error tick count: expected %0d, actual %0d", exp_inc, act_inc);
            end
        end
    endtask

    initial
    begin
        logic [7:0] exp_tm_key;
        logic [7:0] exp_led;
        rst_n      = 1'b0;
        btn        = '0;
        sw         = '0;
        mic_sample = 12'h800;
        seed       = 32'hc3ac_2708;
        cyc        = 0;
        frame_cnt  = 0;
        err_cnt    = 0;
        check_cnt  = 0;
        timed_out  = 1'b0;
        cur_count  = -1;
        prev_count = -1;
        cur_start  = 0;
        prev_start = 0;
        for (int k = 0; k < 4; k++)
            key_bytes[k] = 8'h00;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        for (int iter = 0; iter < 6; iter++)
        begin
            @(negedge clk);
            seed       = lcg_next(seed);
            mic_sample = seed[27:16];
            seed       = lcg_next(seed);
            btn        = seed[19:16];
            sw         = seed[23:20];
            for (int k = 0; k < 4; k++)
            begin
                seed         = lcg_next(seed);
                key_bytes[k] = seed[23:16];
            end
            // key k sits in bit 0 of read byte k, key k+4 in bit 4
            for (int k = 0; k < 4; k++)
            begin
                exp_tm_key[k]     = key_bytes[k][0];
                exp_tm_key[k + 4] = key_bytes[k][4];
            end
            exp_led = (exp_tm_key | {4'd0, btn}) ^ {4'd0, sw};

            wait_frames(2);
            if (timed_out)
                break;
            repeat (2) @(negedge clk);
            check_value("keys to leds", exp_led[3:0], led);
            wait_frames(1);
            if (timed_out)
                break;
            check_frame(exp_led);
        end

        $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

//--- sources.f
design/board_pkg.sv
design/slow_tick_gen.sv
design/mic3_spi_receiver.sv
design/tm1638_controller.sv
design/lab_top.sv
design/board_top.sv
verification/tb_clock.sv
verification/board_top_properties.sv
verification/board_top_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and decide the result from the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module board_top_tb \
    -f sources.f -o board_top_sim > build.log 2>&1 \
    && ./obj_dir/board_top_sim > sim.log 2>&1 \
    || { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "Verification failed" sim.log \
    && { echo "simulation FAILED"; exit 1; } \
    || { grep -q "Verification passed" sim.log && echo "simulation PASSED"; } \
    || { echo "no result line in sim.log"; exit 1; }
